// File: bench/lsu_stim.txt
# test kind op addr data bp; data is store data or expected load result, all hex
# load op 0=bs 1=bu 2=hs 3=hu 4=w, store op 0=b 1=h 2=w; bp 1 = random response ready
1 load 4 00000000 00000000 0
1 load 4 000001fc 00000000 0
1 load 4 00000100 00000000 0
2 store 2 00000010 a1b2c3d4 0
2 load 4 00000010 a1b2c3d4 0
2 store 1 00000012 dead5566 0
2 load 4 00000010 5566c3d4 0
2 store 0 00000011 123456ee 0
2 load 4 00000010 5566eed4 0
2 store 0 00000010 00000077 0
2 load 4 00000010 5566ee77 0
3 load 0 00000011 ffffffee 0
3 load 1 00000011 000000ee 0
3 load 1 00000013 00000055 0
3 load 2 00000010 ffffee77 0
3 load 3 00000010 0000ee77 0
3 load 2 00000012 00005566 0
4 store 2 00000014 8899aabb 0
4 load 4 00000014 8899aabb 0
4 load 4 00000010 5566ee77 0
4 load 0 00000017 ffffff88 0
4 store 0 00000015 00000011 0
4 load 4 00000014 889911bb 0
4 load 4 00000010 5566ee77 0
5 store 2 00000010 a1b2c3d4 1
5 load 4 00000010 a1b2c3d4 1
5 store 1 00000012 dead5566 1
5 load 4 00000010 5566c3d4 1
5 store 0 00000011 123456ee 1
5 load 4 00000010 5566eed4 1
5 store 0 00000010 00000077 1
5 load 4 00000010 5566ee77 1
5 load 2 00000016 ffff8899 1
5 load 4 00000014 889911bb 1

// File: project.f
logic/lsu_pkg.sv
logic/decouple_if.sv
logic/axi_if.sv
logic/lsu.sv
logic/axi_sram.sv
logic/lsu_top.sv
bench/lsu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the lsu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f project.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// File: bench/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 30;
  localparam int MAX_LINES    = 256;

  logic              clk;
  logic              rstn;
  logic [ADDR_W-1:0] raddr;
  ld_op_e            rfunc;
  logic              rreq_valid;
  logic              rreq_ready;
  logic [XLEN-1:0]   rdata;
  logic              rres_valid;
  logic              rres_ready;
  st_op_e            wfunc;
  logic [ADDR_W-1:0] waddr;
  logic [XLEN-1:0]   wdata;
  logic              wreq_valid;
  logic              wreq_ready;
  logic              wres_valid;
  logic              wres_ready;

  // one entry per transaction line of the stim file
  int          n_txn;
  int          t_test  [MAX_LINES];
  logic        t_store [MAX_LINES];
  logic [2:0]  t_op    [MAX_LINES];
  logic [31:0] t_addr  [MAX_LINES];
  logic [31:0] t_data  [MAX_LINES];
  logic        t_bp    [MAX_LINES];

  int errors;
  int checks;
  int test_errors;
  int tests_run;
  int tests_failed;
  int cur_line;
  int cycles;
  int cycle_limit = 1000;

  lsu_top dut (.*);

  always #2 clk = ~clk;

  // hard stop in case a handshake hangs
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, stuck in test %0d at stim line %0d",
               cycles, t_test[cur_line], cur_line);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic txn_lost(input int i, input string what);
    errors++;
    test_errors++;
    $display("test %0d line %0d: access to %h %s", t_test[i], i, t_addr[i], what);
  endtask

  task automatic finish_test(input int num);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d: pass", num);
    end else begin
      tests_failed++;
      $display("test %0d: %0d errors", num, test_errors);
    end
    test_errors = 0;
  endtask

  // response ready, low one time in four under back-pressure
  function automatic logic pick_ready(input logic bp);
    if (!bp) begin
      return 1'b1;
    end
    return ($urandom % 4) != 0;
  endfunction

  task automatic read_stim();
    int             fd;
    int             code;
    int             test;
    int             op;
    int             bp;
    string          line;
    logic [39:0]    kind;
    logic [31:0]    addr;
    logic [31:0]    data;
    n_txn = 0;
    fd = $fopen("bench/lsu_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open bench/lsu_stim.txt");
      return;
    end
    while (!$feof(fd) && n_txn < MAX_LINES) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%d %s %d %h %h %d", test, kind, op, addr, data, bp);
        if (code == 6) begin
          t_test[n_txn]  = test;
          t_store[n_txn] = (kind == "store");
          t_op[n_txn]    = op[2:0];
          t_addr[n_txn]  = addr;
          t_data[n_txn]  = data;
          t_bp[n_txn]    = bp[0];
          n_txn++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic do_load(input int i);
    int n;
    @(negedge clk);
    raddr      = t_addr[i];
    rfunc      = ld_op_e'(t_op[i]);
    rreq_valid = 1'b1;
    n = 0;
    #1;
    while (!rreq_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!rreq_ready) begin
      txn_lost(i, "was never accepted on the load request channel");
      @(negedge clk);
      rreq_valid = 1'b0;
      return;
    end
    // request transfers on the coming rising edge
    @(negedge clk);
    rreq_valid = 1'b0;
    rres_ready = pick_ready(t_bp[i]);
    n = 0;
    #1;
    while (!(rres_valid && rres_ready) && n < WAIT_LIMIT) begin
      @(negedge clk);
      rres_ready = pick_ready(t_bp[i]);
      #1;
      n++;
    end
    if (rres_valid && rres_ready) begin
      check("rdata", t_data[i], rdata);
    end else begin
      txn_lost(i, "got no load response");
    end
    @(negedge clk);
    rres_ready = 1'b1;
  endtask

  task automatic do_store(input int i);
    int n;
    @(negedge clk);
    waddr      = t_addr[i];
    wdata      = t_data[i];
    wfunc      = st_op_e'(t_op[i][1:0]);
    wreq_valid = 1'b1;
    n = 0;
    #1;
    while (!wreq_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!wreq_ready) begin
      txn_lost(i, "was never accepted on the store request channel");
      @(negedge clk);
      wreq_valid = 1'b0;
      return;
    end
    @(negedge clk);
    wreq_valid = 1'b0;
    wres_ready = pick_ready(t_bp[i]);
    n = 0;
    #1;
    while (!(wres_valid && wres_ready) && n < WAIT_LIMIT) begin
      @(negedge clk);
      wres_ready = pick_ready(t_bp[i]);
      #1;
      n++;
    end
    if (!(wres_valid && wres_ready)) begin
      txn_lost(i, "got no store response");
    end
    @(negedge clk);
    wres_ready = 1'b1;
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    raddr        = '0;
    rfunc        = LD_W;
    rreq_valid   = 1'b0;
    rres_ready   = 1'b1;
    wfunc        = ST_W;
    waddr        = '0;
    wdata        = '0;
    wreq_valid   = 1'b0;
    wres_ready   = 1'b1;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_line     = 0;
    cycles       = 0;
    void'($urandom(32'h2a20_c953));

    read_stim();
    cycle_limit = n_txn * 40 + 200;

    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;

    // test 0 covers the idle state right out of reset
    check("rres_valid", 32'd0, 32'(rres_valid));
    check("wres_valid", 32'd0, 32'(wres_valid));
    finish_test(0);

    for (int i = 0; i < n_txn; i++) begin
      cur_line = i;
      if (i > 0 && t_test[i] != t_test[i-1]) begin
        finish_test(t_test[i-1]);
      end
      if (t_store[i]) begin
        do_store(i);
      end else begin
        do_load(i);
      end
    end
    if (n_txn > 0) begin
      finish_test(t_test[n_txn-1]);
    end

    $display("tests run %0d, failed %0d, checks %0d, errors %0d, cycles %0d",
             tests_run, tests_failed, checks, errors, cycles);
    if (errors == 0 && n_txn > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
  input  logic                       clk,
  input  logic                       rstn,

  // load channel
  input  logic [lsu_pkg::ADDR_W-1:0] raddr,
  input  lsu_pkg::ld_op_e            rfunc,
  input  logic                       rreq_valid,
  output logic                       rreq_ready,
  output logic [lsu_pkg::XLEN-1:0]   rdata,
  output logic                       rres_valid,
  input  logic                       rres_ready,

  // store channel
  input  lsu_pkg::st_op_e            wfunc,
  input  logic [lsu_pkg::ADDR_W-1:0] waddr,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  input  logic                       wreq_valid,
  output logic                       wreq_ready,
  output logic                       wres_valid,
  input  logic                       wres_ready
);

  decouple_if rreq_if ();
  decouple_if rres_if ();
  decouple_if wreq_if ();
  decouple_if wres_if ();

  axi_if mem_if ();

  // core side handshakes onto the interfaces
  assign rreq_if.valid = rreq_valid;
  assign rreq_ready    = rreq_if.ready;
  assign rres_valid    = rres_if.valid;
  assign rres_if.ready = rres_ready;

  assign wreq_if.valid = wreq_valid;
  assign wreq_ready    = wreq_if.ready;
  assign wres_valid    = wres_if.valid;
  assign wres_if.ready = wres_ready;

  lsu u_lsu (
    .clk   (clk),
    .rstn  (rstn),
    .raddr (raddr),
    .rfunc (rfunc),
    .rreq  (rreq_if),
    .rdata (rdata),
    .rres  (rres_if),
    .wfunc (wfunc),
    .waddr (waddr),
    .wdata (wdata),
    .wreq  (wreq_if),
    .wres  (wres_if),
    .mem   (mem_if)
  );

  // both AXI directions share one interface instance
  axi_sram u_sram (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_if)
  );

endmodule

`default_nettype wire

// File: logic/axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram (
  input  logic  clk,
  input  logic  rstn,
  axi_if.slave  bus
);
  import lsu_pkg::*;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_HAVE_AW,
    WR_HAVE_W,
    WR_COMMIT,
    WR_RESP
  } wr_state_e;

  logic [BUS_W-1:0] mem [MEM_WORDS];

  // read side
  logic                 rvalid_q;
  logic [BUS_W-1:0]     rdata_q;
  logic [MEM_IDX_W-1:0] ar_idx;

  // write side
  wr_state_e            wr_state;
  wr_state_e            wr_next;
  logic [MEM_IDX_W-1:0] aw_idx_q;
  logic [BUS_W-1:0]     wdata_q;
  logic [STRB_W-1:0]    wstrb_q;
  logic [BUS_W-1:0]     merged;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 b_fire;

  assign ar_idx = bus.araddr[MEM_IDX_W+2:3];

  // one response slot, so no new address until it drains
  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rvalid_q <= 1'b0;
    end else if (bus.arvalid && bus.arready) begin
      rvalid_q <= 1'b1;
    end else if (bus.rvalid && bus.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.arvalid && bus.arready) begin
      rdata_q <= mem[ar_idx];
    end
  end

  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire  = bus.wvalid && bus.wready;
  assign b_fire  = bus.bvalid && bus.bready;

  // AW and W each taken once, in either order
  assign bus.awready = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_W);
  assign bus.wready  = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_AW);
  assign bus.bvalid  = (wr_state == WR_RESP);

  always_comb begin
    wr_next = wr_state;
    case (wr_state)
      WR_IDLE: begin
        if (aw_fire && w_fire) begin
          wr_next = WR_COMMIT;
        end else if (aw_fire) begin
          wr_next = WR_HAVE_AW;
        end else if (w_fire) begin
          wr_next = WR_HAVE_W;
        end
      end
      WR_HAVE_AW: if (w_fire) wr_next = WR_COMMIT;
      WR_HAVE_W:  if (aw_fire) wr_next = WR_COMMIT;
      WR_COMMIT:  wr_next = WR_RESP;
      WR_RESP:    if (b_fire) wr_next = WR_IDLE;
      default:    wr_next = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_idx_q <= bus.awaddr[MEM_IDX_W+2:3];
    end
    if (w_fire) begin
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end
  end

  // byte merge of the captured beat into the stored word
  always_comb begin
    merged = mem[aw_idx_q];
    for (int b = 0; b < STRB_W; b++) begin
      if (wstrb_q[b]) begin
        merged[b*8 +: 8] = wdata_q[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_state == WR_COMMIT) begin
      mem[aw_idx_q] <= merged;
    end
  end

  a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
    bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata))
    else $error("read response dropped before rready");

  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    bus.bvalid && !bus.bready |=> bus.bvalid)
    else $error("write response dropped before bready");

  // single beat slave, every W beat must be the last
  a_w_last: assert property (@(posedge clk) disable iff (!rstn)
    bus.wvalid |-> bus.wlast)
    else $error("burst write beat seen");

endmodule

`default_nettype wire

// File: logic/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
  input  logic                       clk,
  input  logic                       rstn,

  // load request and response
  input  logic [lsu_pkg::ADDR_W-1:0] raddr,
  input  lsu_pkg::ld_op_e            rfunc,
  decouple_if.in                     rreq,
  output logic [lsu_pkg::XLEN-1:0]   rdata,
  decouple_if.out                    rres,

  // store request and response
  input  lsu_pkg::st_op_e            wfunc,
  input  logic [lsu_pkg::ADDR_W-1:0] waddr,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  decouple_if.in                     wreq,
  decouple_if.out                    wres,

  // memory side
  axi_if.master                      mem
);
  import lsu_pkg::*;

  // opcode and byte offset of the load in flight
  ld_op_e           rfunc_q;
  logic [2:0]       roff_q;
  logic [BUS_W-1:0] rbeat_shifted;

  // set while that write channel is still to be sent
  logic              aw_pend;
  logic              w_pend;
  logic [STRB_W-1:0] wmask;

  // low address bits that must be zero for a given axi size
  function automatic logic misaligned(input logic [2:0] addr, input logic [2:0] size);
    logic [2:0] lo_mask;
    lo_mask = (3'd1 << size) - 3'd1;
    return (addr & lo_mask) != 3'd0;
  endfunction

  // load request goes straight out on AR
  assign mem.arvalid = rreq.valid;
  assign mem.araddr  = raddr;
  assign rreq.ready  = mem.arready;

  always_comb begin
    case (rfunc)
      LD_BS, LD_BU: mem.arsize = AXI_SIZE_B;
      LD_HS, LD_HU: mem.arsize = AXI_SIZE_H;
      default:      mem.arsize = AXI_SIZE_W;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rreq.valid && rreq.ready) begin
      rfunc_q <= rfunc;
      roff_q  <= raddr[2:0];
    end
  end

  // bring the addressed byte down to lane 0
  assign rbeat_shifted = mem.rdata >> {roff_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      LD_BS:   rdata = {{24{rbeat_shifted[7]}}, rbeat_shifted[7:0]};
      LD_BU:   rdata = {24'b0, rbeat_shifted[7:0]};
      LD_HS:   rdata = {{16{rbeat_shifted[15]}}, rbeat_shifted[15:0]};
      LD_HU:   rdata = {16'b0, rbeat_shifted[15:0]};
      default: rdata = rbeat_shifted[XLEN-1:0];
    endcase
  end

  // response errors are never reported by the ram
  assign rres.valid = mem.rvalid;
  assign mem.rready = rres.ready;

  // store size and byte mask before lane shift
  always_comb begin
    case (wfunc)
      ST_H: begin
        mem.awsize = AXI_SIZE_H;
        wmask      = STRB_W'(8'b0000_0011);
      end
      ST_W: begin
        mem.awsize = AXI_SIZE_W;
        wmask      = STRB_W'(8'b0000_1111);
      end
      default: begin
        mem.awsize = AXI_SIZE_B;
        wmask      = STRB_W'(8'b0000_0001);
      end
    endcase
  end

  assign mem.awaddr = waddr;
  assign mem.wdata  = {{(BUS_W-XLEN){1'b0}}, wdata} << {waddr[2:0], 3'b000};
  assign mem.wstrb  = wmask << waddr[2:0];
  assign mem.wlast  = 1'b1;

  // each channel presented once per store
  assign mem.awvalid = wreq.valid & aw_pend;
  assign mem.wvalid  = wreq.valid & w_pend;

  // accept only in the cycle the last outstanding channel completes
  assign wreq.ready = (aw_pend | w_pend)
                    & (mem.awready | ~aw_pend)
                    & (mem.wready | ~w_pend);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else if (mem.bvalid && mem.bready) begin
      // re-arm for the next store
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (mem.awvalid && mem.awready) begin
        aw_pend <= 1'b0;
      end
      if (mem.wvalid && mem.wready) begin
        w_pend <= 1'b0;
      end
    end
  end

  assign wres.valid = mem.bvalid;
  assign mem.bready = wres.ready;

  // misaligned accesses are never split
  a_ld_aligned: assert property (@(posedge clk) disable iff (!rstn)
    mem.arvalid |-> !misaligned(mem.araddr[2:0], mem.arsize))
    else $error("misaligned load at %h", mem.araddr);

  a_st_aligned: assert property (@(posedge clk) disable iff (!rstn)
    mem.awvalid |-> !misaligned(mem.awaddr[2:0], mem.awsize))
    else $error("misaligned store at %h", mem.awaddr);

  // strobe is nonzero and covers exactly the bytes of the store size
  a_wstrb_set: assert property (@(posedge clk) disable iff (!rstn)
    mem.wvalid |-> $countones(mem.wstrb) == (1 << mem.awsize))
    else $error("write strobe %h does not fit size %0d", mem.wstrb, mem.awsize);

endmodule

`default_nettype wire

// File: logic/axi_if.sv
`timescale 1ns/10ps
`default_nettype none

interface axi_if;
  import lsu_pkg::*;

  // read address
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic [2:0]        arsize;

  // read data
  logic              rvalid;
  logic              rready;
  logic [BUS_W-1:0]  rdata;

  // write address
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic [2:0]        awsize;

  // write data, always a single beat
  logic              wvalid;
  logic              wready;
  logic [BUS_W-1:0]  wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wlast;

  // write response
  logic              bvalid;
  logic              bready;

  modport master (
    output arvalid, araddr, arsize, input arready,
    input  rvalid, rdata, output rready,
    output awvalid, awaddr, awsize, input awready,
    output wvalid, wdata, wstrb, wlast, input wready,
    input  bvalid, output bready
  );

  modport slave (
    input  arvalid, araddr, arsize, output arready,
    output rvalid, rdata, input rready,
    input  awvalid, awaddr, awsize, output awready,
    input  wvalid, wdata, wstrb, wlast, output wready,
    output bvalid, input bready
  );

endinterface

`default_nettype wire

// File: logic/decouple_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decouple_if;

  // producer drives valid, consumer drives ready
  logic valid;
  logic ready;

  // consumer side
  modport in (
    input  valid,
    output ready
  );

  // producer side
  modport out (
    output valid,
    input  ready
  );

endinterface

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // core side widths
  localparam int ADDR_W = 32;
  localparam int XLEN   = 32;

  // memory bus widths
  localparam int BUS_W  = 64;
  localparam int STRB_W = BUS_W / 8;

  // ram depth in bus words, 512 bytes total
  localparam int MEM_WORDS = 64;
  // word index taken from address bits 8..3
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // axi size field encodings
  localparam logic [2:0] AXI_SIZE_B = 3'd0;
  localparam logic [2:0] AXI_SIZE_H = 3'd1;
  localparam logic [2:0] AXI_SIZE_W = 3'd2;

  // load opcodes
  // signed and unsigned variants for byte and halfword
  typedef enum logic [2:0] {
    LD_BS,
    LD_BU,
    LD_HS,
    LD_HU,
    LD_W
  } ld_op_e;

  // store opcodes
  typedef enum logic [1:0] {
    ST_B,
    ST_H,
    ST_W
  } st_op_e;

endpackage

`default_nettype wire
